// ==== src/ifu_cfg.svh ====
`ifndef IFU_CFG_SVH
`define IFU_CFG_SVH

// fetch starts here after reset
`define IFU_PC_INIT 32'h8000_0000

`define IFU_XLEN 32

// four sets of two-word lines
`define IFU_L1I_SETS_LOG 2
`define IFU_L1I_LINE_LOG 1

`define IFU_L1I_SETS  (1 << `IFU_L1I_SETS_LOG)
`define IFU_L1I_WORDS (1 << `IFU_L1I_LINE_LOG)

// pc bits above index, offset and byte lane
`define IFU_L1I_TAG_W (`IFU_XLEN - `IFU_L1I_SETS_LOG - `IFU_L1I_LINE_LOG - 2)

`endif

// ==== src/ifu_isa_pkg.sv ====
`include "ifu_cfg.svh"

package ifu_isa_pkg;

  // major opcodes the fetch stage cares about
  typedef enum logic [6:0] {
    OP_JAL      = 7'b1101111,
    OP_JALR     = 7'b1100111,
    OP_BRANCH   = 7'b1100011,
    OP_SYSTEM   = 7'b1110011,
    OP_LOAD     = 7'b0000011,
    OP_STORE    = 7'b0100011,
    OP_MISC_MEM = 7'b0001111
  } opcode_e;

  localparam logic [`IFU_XLEN-1:0] FENCE_I = 32'h0000_100f;

  typedef enum logic [2:0] {
    PLAIN,
    CONTROL,  // jal, jalr, branch, system
    LOAD,
    STORE,
    FENCE     // fence.i only, a plain fence counts as PLAIN
  } fetch_class_e;

  typedef struct packed {
    logic [`IFU_XLEN-1:0] pc;
    logic [`IFU_XLEN-1:0] inst;
  } fetch_pkt_t;

endpackage

// ==== src/ifu_mem_pkg.sv ====
`include "ifu_cfg.svh"

package ifu_mem_pkg;

  // refill sequence of the instruction cache
  typedef enum logic [2:0] {
    IDLE,
    WORD0,   // request even word, wait for data
    GAP,
    WORD1,   // request odd word, wait for data
    SETTLE
  } refill_e;

  typedef logic [`IFU_L1I_TAG_W-1:0] tag_t;
  typedef logic [`IFU_L1I_SETS_LOG-1:0] index_t;
  typedef logic [`IFU_L1I_LINE_LOG-1:0] offset_t;  // word within line

endpackage

// ==== src/ifu_lookup_if.sv ====
`timescale 1ns/1ns
`include "ifu_cfg.svh"

interface ifu_lookup_if;

  logic [`IFU_XLEN-1:0] pc;
  logic                 hit;   // inst belongs to pc this cycle
  logic [`IFU_XLEN-1:0] inst;
  logic                 idle;  // no refill running, pc may move
  logic                 flush; // fence.i accepted by decode

  // address fields of the current pc
  ifu_mem_pkg::tag_t    pc_tag;
  ifu_mem_pkg::index_t  pc_index;
  ifu_mem_pkg::offset_t pc_offset;

  assign {pc_tag, pc_index, pc_offset} = pc[`IFU_XLEN-1:2];

  modport ctrl (
    output pc,
    output flush,
    input  hit,
    input  inst,
    input  idle
  );

  modport cache (
    input  pc_tag,
    input  pc_index,
    input  pc_offset,
    input  flush,
    output hit,
    output inst,
    output idle
  );

endinterface

// ==== src/ifu_pc_ctrl.sv ====
`timescale 1ns/1ns
`include "ifu_cfg.svh"

module ifu_pc_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  ifu_lookup_if.ctrl           lookup,
  input  logic                 ready_i,
  output logic                 valid_o,
  output logic [`IFU_XLEN-1:0] inst_o,
  output logic [`IFU_XLEN-1:0] pc_o,
  input  logic                 redirect_i,
  input  logic [`IFU_XLEN-1:0] npc_i,
  input  logic                 retire_i,
  input  logic [`IFU_XLEN-1:0] retire_pc_i,
  output logic                 spec_o,
  output logic                 good_spec_o,
  output logic                 bad_spec_o
);

  localparam logic [`IFU_XLEN-1:0] WORD_STEP = 4;

  logic [`IFU_XLEN-1:0] pc_q;
  logic [`IFU_XLEN-1:0] btb_q;      // last redirect target
  logic                 btb_valid_q;
  logic [`IFU_XLEN-1:0] pred_q;     // predicted next pc of the open speculation
  logic [`IFU_XLEN-1:0] fall_q;     // fall-through of the predicted instruction
  logic [`IFU_XLEN-1:0] restart_q;
  logic                 spec_q;
  logic                 spec_br_q;  // open prediction is a conditional branch
  logic                 hazard_q;
  logic                 bad_q;
  logic                 good_q;

  ifu_isa_pkg::opcode_e      opcode;
  ifu_isa_pkg::fetch_class_e cls;
  ifu_isa_pkg::fetch_pkt_t   pkt;

  logic                 fire;
  logic                 report;
  logic [`IFU_XLEN-1:0] report_pc;
  logic                 match;
  logic                 mismatch;
  logic                 mem_blocked;

  function automatic ifu_isa_pkg::fetch_class_e classify(
    input ifu_isa_pkg::opcode_e op,
    input logic [`IFU_XLEN-1:0] inst
  );
    if (inst == ifu_isa_pkg::FENCE_I) begin
      return ifu_isa_pkg::FENCE;
    end
    case (op)
      ifu_isa_pkg::OP_JAL,
      ifu_isa_pkg::OP_JALR,
      ifu_isa_pkg::OP_BRANCH,
      ifu_isa_pkg::OP_SYSTEM: return ifu_isa_pkg::CONTROL;
      ifu_isa_pkg::OP_LOAD:   return ifu_isa_pkg::LOAD;
      ifu_isa_pkg::OP_STORE:  return ifu_isa_pkg::STORE;
      default:                return ifu_isa_pkg::PLAIN;
    endcase
  endfunction

  assign opcode = ifu_isa_pkg::opcode_e'(lookup.inst[6:0]);
  assign cls    = classify(opcode, lookup.inst);

  assign pkt.pc   = pc_q;
  assign pkt.inst = lookup.inst;
  assign pc_o     = pkt.pc;
  assign inst_o   = pkt.inst;

  assign lookup.pc = pc_q;

  // memory ops wait until the open prediction is resolved
  assign mem_blocked = spec_q & ((cls == ifu_isa_pkg::LOAD) | (cls == ifu_isa_pkg::STORE));

  assign valid_o = lookup.hit & !hazard_q & !bad_spec_o & !mem_blocked;
  assign fire    = valid_o & ready_i;

  assign lookup.flush = fire & (cls == ifu_isa_pkg::FENCE);

  // the first report after a prediction belongs to the predicted instruction
  assign report    = redirect_i | retire_i;
  assign report_pc = redirect_i ? npc_i : retire_pc_i + WORD_STEP;
  assign match     = spec_q & report & (report_pc == pred_q);
  assign mismatch  = spec_q & report & (report_pc != pred_q);

  assign spec_o      = spec_q;
  assign good_spec_o = good_q;
  assign bad_spec_o  = bad_q | mismatch;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q        <= `IFU_PC_INIT;
      btb_valid_q <= 1'b0;
      spec_q      <= 1'b0;
      spec_br_q   <= 1'b0;
      hazard_q    <= 1'b0;
      bad_q       <= 1'b0;
      good_q      <= 1'b0;
    end else begin
      good_q <= match;
      if (redirect_i) begin
        btb_q       <= npc_i;
        btb_valid_q <= 1'b1;
      end
      if (match) begin
        spec_q <= 1'b0;
      end
      if (mismatch) begin
        spec_q    <= 1'b0;
        bad_q     <= 1'b1;
        restart_q <= (spec_br_q & !redirect_i) ? fall_q : npc_i;
      end
      // stalled instruction reported, continue from its real successor
      if (hazard_q & report & !spec_q) begin
        hazard_q <= 1'b0;
        pc_q     <= redirect_i ? npc_i : pc_q + WORD_STEP;
      end
      if (bad_q & ready_i & lookup.idle) begin
        bad_q    <= 1'b0;
        hazard_q <= 1'b0;
        pc_q     <= restart_q;
      end
      if (fire) begin
        case (cls)
          ifu_isa_pkg::CONTROL: begin
            if (btb_valid_q & !spec_q) begin
              pc_q      <= btb_q;
              pred_q    <= btb_q;
              fall_q    <= pc_q + WORD_STEP;
              spec_q    <= 1'b1;
              spec_br_q <= (opcode == ifu_isa_pkg::OP_BRANCH);
            end else begin
              hazard_q <= 1'b1;  // nothing to predict from
            end
          end
          ifu_isa_pkg::LOAD,
          ifu_isa_pkg::FENCE: hazard_q <= 1'b1;
          default:            pc_q <= pc_q + WORD_STEP;
        endcase
      end
    end
  end

endmodule

// ==== src/ifu_l1i.sv ====
`timescale 1ns/1ns
`include "ifu_cfg.svh"

module ifu_l1i (
  input  logic                 clk,
  input  logic                 rst,
  ifu_lookup_if.cache          lookup,
  output logic [`IFU_XLEN-1:0] araddr_o,
  output logic                 arvalid_o,
  input  logic                 arready_i,
  input  logic [`IFU_XLEN-1:0] rdata_i,
  input  logic                 rvalid_i
);

  ifu_mem_pkg::refill_e state_q;
  logic                 ar_done_q;  // address of the current word taken by memory

  logic [`IFU_L1I_SETS-1:0] valid_q;
  ifu_mem_pkg::tag_t        tag_q  [`IFU_L1I_SETS];
  logic [`IFU_XLEN-1:0]     data_q [`IFU_L1I_SETS][`IFU_L1I_WORDS];

  logic                 line_ok;
  logic                 word_in;
  ifu_mem_pkg::offset_t fill_off;

  assign line_ok = valid_q[lookup.pc_index] & (tag_q[lookup.pc_index] == lookup.pc_tag);

  assign lookup.hit  = (state_q == ifu_mem_pkg::IDLE) & line_ok;
  assign lookup.idle = (state_q == ifu_mem_pkg::IDLE);
  assign lookup.inst = data_q[lookup.pc_index][lookup.pc_offset];

  // even word first, odd word second
  assign fill_off = ifu_mem_pkg::offset_t'(state_q == ifu_mem_pkg::WORD1);
  assign araddr_o = {lookup.pc_tag, lookup.pc_index, fill_off, 2'b00};

  // pc may have moved onto a resident line on the idle edge, drop the request then
  assign arvalid_o = !ar_done_q &
    ((state_q == ifu_mem_pkg::WORD1) | ((state_q == ifu_mem_pkg::WORD0) & !line_ok));

  assign word_in = ar_done_q & rvalid_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= ifu_mem_pkg::IDLE;
      ar_done_q <= 1'b0;
      valid_q   <= '0;
    end else begin
      if (arvalid_o & arready_i) begin
        ar_done_q <= 1'b1;
      end
      case (state_q)
        ifu_mem_pkg::IDLE: begin
          if (!line_ok) begin
            state_q <= ifu_mem_pkg::WORD0;
          end
        end
        ifu_mem_pkg::WORD0: begin
          if (!ar_done_q & line_ok) begin
            state_q <= ifu_mem_pkg::IDLE;
          end else if (word_in) begin
            state_q                   <= ifu_mem_pkg::GAP;
            ar_done_q                 <= 1'b0;
            valid_q[lookup.pc_index]  <= 1'b0;  // old line is being overwritten
          end
        end
        ifu_mem_pkg::GAP: state_q <= ifu_mem_pkg::WORD1;
        ifu_mem_pkg::WORD1: begin
          if (word_in) begin
            state_q                  <= ifu_mem_pkg::SETTLE;
            ar_done_q                <= 1'b0;
            valid_q[lookup.pc_index] <= 1'b1;
          end
        end
        ifu_mem_pkg::SETTLE: state_q <= ifu_mem_pkg::IDLE;
        default:             state_q <= ifu_mem_pkg::IDLE;
      endcase
      if (lookup.flush) begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (word_in) begin
      data_q[lookup.pc_index][fill_off] <= rdata_i;
    end
    if (word_in & (state_q == ifu_mem_pkg::WORD1)) begin
      tag_q[lookup.pc_index] <= lookup.pc_tag;
    end
  end

endmodule

// ==== src/ifu_top.sv ====
`timescale 1ns/1ns
`include "ifu_cfg.svh"

module ifu_top (
  input  logic                 clk,
  input  logic                 rst,

  // instruction read bus
  output logic [`IFU_XLEN-1:0] araddr_o,
  output logic                 arvalid_o,
  input  logic                 arready_i,
  input  logic [`IFU_XLEN-1:0] rdata_i,
  input  logic                 rvalid_i,

  // decode
  output logic [`IFU_XLEN-1:0] inst_o,
  output logic [`IFU_XLEN-1:0] pc_o,
  output logic                 valid_o,
  input  logic                 ready_i,

  // backend report
  input  logic                 redirect_i,
  input  logic [`IFU_XLEN-1:0] npc_i,
  input  logic                 retire_i,
  input  logic [`IFU_XLEN-1:0] retire_pc_i,

  output logic                 spec_o,
  output logic                 good_spec_o,
  output logic                 bad_spec_o
);

  ifu_lookup_if lookup ();

  ifu_pc_ctrl pc_ctrl_i (
    .clk         (clk),
    .rst         (rst),
    .lookup      (lookup.ctrl),
    .ready_i     (ready_i),
    .valid_o     (valid_o),
    .inst_o      (inst_o),
    .pc_o        (pc_o),
    .redirect_i  (redirect_i),
    .npc_i       (npc_i),
    .retire_i    (retire_i),
    .retire_pc_i (retire_pc_i),
    .spec_o      (spec_o),
    .good_spec_o (good_spec_o),
    .bad_spec_o  (bad_spec_o)
  );

  ifu_l1i l1i_i (
    .clk       (clk),
    .rst       (rst),
    .lookup    (lookup.cache),
    .araddr_o  (araddr_o),
    .arvalid_o (arvalid_o),
    .arready_i (arready_i),
    .rdata_i   (rdata_i),
    .rvalid_i  (rvalid_i)
  );

endmodule

// ==== bench/ifu_sva.sv ====
`timescale 1ns/1ns
`include "ifu_cfg.svh"

module ifu_sva (
  input logic                 clk,
  input logic                 rst,
  input logic                 valid_o,
  input logic                 ready_i,
  input logic [`IFU_XLEN-1:0] pc_o,
  input logic [`IFU_XLEN-1:0] inst_o,
  input logic                 arvalid_o,
  input logic                 arready_i,
  input logic [`IFU_XLEN-1:0] araddr_o,
  input logic                 rvalid_i,
  input logic                 spec_o,
  input logic                 good_spec_o,
  input logic                 bad_spec_o,
  input ifu_mem_pkg::refill_e state_i
);

  int err_cnt = 0;  // read by the bench

  reset_values: assert property (@(posedge clk) rst |=> !valid_o && !arvalid_o && !spec_o
      && !good_spec_o && !bad_spec_o && (pc_o == `IFU_PC_INIT))
    else begin
      err_cnt++;
      $error("FAILED at %0t: outputs not in reset state", $time);
    end

  hold_on_stall: assert property (@(posedge clk) disable iff (rst)
      valid_o && !ready_i |=> $stable(pc_o) && $stable(inst_o))
    else begin
      err_cnt++;
      $error("FAILED at %0t: pc or inst moved under back-pressure", $time);
    end

  addr_stable: assert property (@(posedge clk) disable iff (rst)
      arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
    else begin
      err_cnt++;
      $error("FAILED at %0t: read address dropped or changed while waiting", $time);
    end

  // the refill must still be waiting when its data comes back
  data_in_word_state: assert property (@(posedge clk) disable iff (rst)
      rvalid_i |-> (state_i == ifu_mem_pkg::WORD0) || (state_i == ifu_mem_pkg::WORD1))
    else begin
      err_cnt++;
      $error("FAILED at %0t: read data arrived while no word was awaited", $time);
    end

endmodule

bind ifu_top ifu_sva ifu_sva_i (
  .clk         (clk),
  .rst         (rst),
  .valid_o     (valid_o),
  .ready_i     (ready_i),
  .pc_o        (pc_o),
  .inst_o      (inst_o),
  .arvalid_o   (arvalid_o),
  .arready_i   (arready_i),
  .araddr_o    (araddr_o),
  .rvalid_i    (rvalid_i),
  .spec_o      (spec_o),
  .good_spec_o (good_spec_o),
  .bad_spec_o  (bad_spec_o),
  .state_i     (l1i_i.state_q)
);

// ==== bench/ifu_tb.sv ====
`timescale 1ns/1ns
`include "ifu_cfg.svh"

module ifu_tb;

  localparam logic [31:0] BASE    = `IFU_PC_INIT;
  localparam logic [31:0] END_PC  = BASE + 32'h2c;
  localparam int          TIMEOUT = 4000;  // ~30 fetches and ~8 refills, each far below 100 cycles
  localparam int          IDX_LO  = `IFU_L1I_LINE_LOG + 2;
  localparam int          TAG_LO  = IDX_LO + `IFU_L1I_SETS_LOG;

  // how the backend resolves each program word
  localparam logic [2:0] K_PLAIN  = 3'd0;
  localparam logic [2:0] K_LOAD   = 3'd1;
  localparam logic [2:0] K_FENCE  = 3'd2;
  localparam logic [2:0] K_JUMP   = 3'd3;
  localparam logic [2:0] K_BRANCH = 3'd4;

  logic        clk, rst;
  logic        arready_i, rvalid_i, ready_i, redirect_i, retire_i;
  logic [31:0] rdata_i, npc_i, retire_pc_i;
  logic [31:0] araddr_o, inst_o, pc_o;
  logic        arvalid_o, valid_o, spec_o, good_spec_o, bad_spec_o;

  logic [31:0] prog [16];
  logic [2:0]  tbl_kind [16];
  logic [31:0] tbl_tgt [16];

  // reference model of the stage
  logic [31:0] exp_pc, btb, spec_pred, first_addr, pend_addr;
  logic        btb_ok, spec_open, blocked, good_due, ar_odd, pend, done;
  logic [`IFU_L1I_SETS-1:0] sh_valid;
  logic [31:0] sh_tag [`IFU_L1I_SETS];
  int          seed, cyc, tick, br_visits, pend_due;

  ifu_top ifu_top_i (.*);

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    if (addr[31:6] == BASE[31:6]) begin
      return prog[addr[5:2]];
    end
    return {addr[31:7] ^ addr[24:0], 7'h13};  // harmless op-imm outside the program
  endfunction

  function automatic logic [`IFU_L1I_SETS_LOG-1:0] idx_of(input logic [31:0] addr);
    return addr[IDX_LO +: `IFU_L1I_SETS_LOG];
  endfunction

  function automatic logic [31:0] tag_of(input logic [31:0] addr);
    return addr >> TAG_LO;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic load_program();
    for (int i = 0; i < 16; i++) begin
      prog[i]     = 32'h0000_0013;
      tbl_kind[i] = K_PLAIN;
      tbl_tgt[i]  = 32'h0;
    end
    prog[0]  = 32'h0010_0093;  // addi
    prog[1]  = 32'h0000_a103;  // lw
    tbl_kind[1] = K_LOAD;
    prog[2]  = 32'h0080_006f;
    tbl_kind[2] = K_JUMP;
    tbl_tgt[2]  = BASE + 32'h10;
    prog[4]  = 32'h0011_8193;  // loop head
    prog[5]  = 32'h0041_8863;
    tbl_kind[5] = K_BRANCH;
    tbl_tgt[5]  = BASE + 32'h24;
    prog[6]  = 32'h0030_a023;  // sw
    prog[7]  = 32'hff5f_f06f;
    tbl_kind[7] = K_JUMP;
    tbl_tgt[7]  = BASE + 32'h10;
    prog[9]  = ifu_isa_pkg::FENCE_I;
    tbl_kind[9] = K_FENCE;
    prog[10] = 32'h0020_0113;
    prog[11] = 32'h0030_0193;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    tick = tick + 1;
    if (tick >= TIMEOUT) begin
      $display("timeout: the program did not finish within %0d cycles", TIMEOUT);
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

  always @(posedge clk) begin
    if (ifu_top_i.ifu_sva_i.err_cnt != 0) begin
      $display("FAILED at %0t ns: a checker assertion fired", $time);
      $display("sim failed");
      $fatal(1, "checker assertion");
    end
  end

  always @(posedge clk) begin
    logic [31:0] rnd;
    logic [31:0] rep_pc;
    logic [31:0] nxt;
    logic [31:0] old_btb;
    logic [3:0]  slot;
    logic [2:0]  kind;
    logic        old_spec;
    logic        old_btb_ok;
    logic        old_blocked;
    if (!rst) begin
      cyc = cyc + 1;
      rnd = $random(seed);
      ready_i    <= rnd[2:0] != 3'd0;  // decode stalls about one cycle in eight
      arready_i  <= rnd[4:3] != 2'd0;
      redirect_i <= 1'b0;
      retire_i   <= 1'b0;
      rvalid_i   <= 1'b0;
      old_spec    = spec_open;
      old_btb     = btb;
      old_btb_ok  = btb_ok;
      old_blocked = blocked;

      assert (spec_o == old_spec) else stop_on_error("spec_o differs from the open prediction");
      assert (good_spec_o == good_due) else stop_on_error("good_spec_o does not follow the report");
      good_due = 1'b0;
      if (redirect_i || retire_i) begin
        rep_pc = redirect_i ? npc_i : retire_pc_i + 32'd4;
        if (old_spec && (rep_pc == spec_pred)) begin
          good_due = 1'b1;
        end else if (old_spec) begin
          assert (bad_spec_o) else stop_on_error("mismatching report without bad_spec_o");
        end
        if (redirect_i) begin
          btb    = npc_i;
          btb_ok = 1'b1;
        end
        spec_open = 1'b0;
        blocked   = 1'b0;
      end

      if (valid_o && ready_i) begin
        slot = pc_o[5:2];
        kind = tbl_kind[slot];
        assert (pc_o == exp_pc) else stop_on_error("delivered pc is out of program order");
        assert (inst_o == mem_word(pc_o)) else stop_on_error("delivered inst differs from memory");
        assert (!old_blocked) else stop_on_error("delivery before the load or fence.i report");
        nxt = pc_o + 32'd4;
        if (kind == K_JUMP) begin
          nxt = tbl_tgt[slot];
        end
        if (kind == K_BRANCH) begin
          br_visits = br_visits + 1;
          if (br_visits == 2) nxt = tbl_tgt[slot];  // loop exit on the second pass
        end
        if (nxt != pc_o + 32'd4) begin
          redirect_i <= 1'b1;
          npc_i      <= nxt;
        end else begin
          retire_i    <= 1'b1;
          retire_pc_i <= pc_o;
        end
        if ((kind == K_JUMP || kind == K_BRANCH) && old_btb_ok && !old_spec) begin
          spec_open = 1'b1;
          spec_pred = old_btb;
        end
        if (kind == K_LOAD || kind == K_FENCE) blocked = 1'b1;
        if (kind == K_FENCE) sh_valid = '0;
        exp_pc = nxt;
        if (pc_o == END_PC) done = 1'b1;
      end

      // memory side
      if (arvalid_o) begin
        assert (!(sh_valid[idx_of(araddr_o)] && sh_tag[idx_of(araddr_o)] == tag_of(araddr_o)))
          else stop_on_error("refill requested for a resident line");
      end
      if (arvalid_o && arready_i) begin
        assert (!pend) else stop_on_error("second address before the data of the first");
        if (!ar_odd) begin
          assert (araddr_o[2 +: `IFU_L1I_LINE_LOG] == '0) else stop_on_error("refill not even first");
          first_addr = araddr_o;
        end else begin
          assert (araddr_o == first_addr + 32'd4) else stop_on_error("odd word not in same line");
        end
        ar_odd    = !ar_odd;
        pend      = 1'b1;
        pend_addr = araddr_o;
        pend_due  = cyc + 1 + int'(rnd[6:5]);
      end else if (pend && cyc >= pend_due) begin
        rvalid_i <= 1'b1;
        rdata_i  <= mem_word(pend_addr);
        pend      = 1'b0;
        if (pend_addr[2 +: `IFU_L1I_LINE_LOG] == '0) begin
          sh_valid[idx_of(pend_addr)] = 1'b0;
        end else begin
          sh_valid[idx_of(pend_addr)] = 1'b1;
          sh_tag[idx_of(pend_addr)]   = tag_of(pend_addr);
        end
      end
    end
  end

  initial begin
    seed = 73275;
    rst = 1'b1;
    arready_i = 1'b0;
    rdata_i = 32'h0;
    rvalid_i = 1'b0;
    ready_i = 1'b0;
    redirect_i = 1'b0;
    npc_i = 32'h0;
    retire_i = 1'b0;
    retire_pc_i = 32'h0;
    exp_pc = BASE;
    btb = 32'h0;
    btb_ok = 1'b0;
    spec_open = 1'b0;
    spec_pred = 32'h0;
    blocked = 1'b0;
    good_due = 1'b0;
    ar_odd = 1'b0;
    pend = 1'b0;
    done = 1'b0;
    sh_valid = '0;
    cyc = 0;
    tick = 0;
    br_visits = 0;
    load_program();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    wait (done);
    repeat (4) @(posedge clk);
    if (ifu_top_i.ifu_sva_i.err_cnt == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("sim failed");
      $fatal(1, "checker assertions fired");
    end
  end

endmodule

// ==== verilog.f ====
+incdir+src
src/ifu_isa_pkg.sv
src/ifu_mem_pkg.sv
src/ifu_lookup_if.sv
src/ifu_pc_ctrl.sv
src/ifu_l1i.sv
src/ifu_top.sv
bench/ifu_sva.sv
bench/ifu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the fetch stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module ifu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# assertion errors must not stop the run before the bench reports them
out=$(./obj_dir/Vifu_tb +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^sim passed$"; then
  exit 0
fi
exit 1
